/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FLIST     ?= rv_core_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) include/rv_core_defs.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "RESULT: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/rv_alu.sv */
`timescale 1ns/10ps

module rv_alu (
    input  rv_core_pkg::ctrl_t ctrl_i,
    input  rv_core_pkg::word_t a_i,
    input  rv_core_pkg::word_t b_i,
    input  rv_core_pkg::word_t imm_i,
    output rv_core_pkg::word_t result_o
);

    rv_core_pkg::word_t op_b;
    logic [4:0]         shamt;

    assign op_b  = (ctrl_i.use_imm || ctrl_i.is_lui) ? imm_i : b_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl_i.alu_op)
            rv_core_pkg::ALU_ADD: begin
                result_o = a_i + op_b;
            end
            rv_core_pkg::ALU_SUB: begin
                result_o = a_i - op_b;
            end
            rv_core_pkg::ALU_SLL: begin
                result_o = a_i << shamt;
            end
            rv_core_pkg::ALU_SLT: begin
                result_o = {31'd0, $signed(a_i) < $signed(op_b)};
            end
            rv_core_pkg::ALU_SLTU: begin
                result_o = {31'd0, a_i < op_b};
            end
            rv_core_pkg::ALU_XOR: begin
                result_o = a_i ^ op_b;
            end
            rv_core_pkg::ALU_SRL: begin
                result_o = a_i >> shamt;
            end
            rv_core_pkg::ALU_SRA: begin
                result_o = $unsigned($signed(a_i) >>> shamt);
            end
            rv_core_pkg::ALU_OR: begin
                result_o = a_i | op_b;
            end
            rv_core_pkg::ALU_AND: begin
                result_o = a_i & op_b;
            end
            rv_core_pkg::ALU_PASS_B: begin
                result_o = op_b;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* hw/rv_core_pkg.sv */
`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef logic [`RV_RADDR_W-1:0] reg_addr_t;

    // instruction words are always 32 bits in rv32.
    typedef logic [31:0] instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        // lui result straight from operand b.
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        // operand b comes from the immediate.
        logic    use_imm;
        // u-type immediate, operand a unused.
        logic    is_lui;
        // instruction class that writes rd.
        logic    reg_we;
        logic    illegal;
    } ctrl_t;

endpackage

/* hw/rv_core_top.sv */
`timescale 1ns/10ps

module rv_core_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  rv_core_pkg::instr_t    instr_i,
    input  logic                   instr_valid_i,
    output logic                   wb_en_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_data_o,
    output logic                   illegal_o,
    output logic [1:0]             led_o
);

    rv_core_pkg::ctrl_t     ctrl;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;
    rv_core_pkg::word_t     imm;
    rv_core_pkg::word_t     result;
    logic                   wb_en;

    rv_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .rst_ni        (rst_ni),
        .ctrl_o        (ctrl),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .rd_o          (rd),
        .wb_en_o       (wb_en),
        .illegal_o     (illegal_o)
    );

    rv_regfile u_regfile (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .rs1_i  (rs1),
        .rs2_i  (rs2),
        .rd_i   (rd),
        .wd_i   (result),
        .we_i   (wb_en),
        .rd1_o  (rs1_data),
        .rd2_o  (rs2_data),
        .led_o  (led_o)
    );

    rv_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .ctrl_i  (ctrl),
        .imm_o   (imm)
    );

    rv_alu u_alu (
        .ctrl_i   (ctrl),
        .a_i      (rs1_data),
        .b_i      (rs2_data),
        .imm_i    (imm),
        .result_o (result)
    );

    assign wb_en_o   = wb_en;
    assign wb_rd_o   = rd;
    assign wb_data_o = result;

endmodule

/* hw/rv_decoder.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_decoder (
    input  rv_core_pkg::instr_t    instr_i,
    input  logic                   instr_valid_i,
    input  logic                   rst_ni,
    output rv_core_pkg::ctrl_t     ctrl_o,
    output rv_core_pkg::reg_addr_t rs1_o,
    output rv_core_pkg::reg_addr_t rs2_o,
    output rv_core_pkg::reg_addr_t rd_o,
    output logic                   wb_en_o,
    output logic                   illegal_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv_core_pkg::ctrl_t ctrl;

    // alt picks sub over add and sra over srl.
    function automatic rv_core_pkg::alu_op_e alu_op_of(
        input logic [2:0] f3,
        input logic       alt
    );
        rv_core_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  op = rv_core_pkg::ALU_SLL;
            3'b010:  op = rv_core_pkg::ALU_SLT;
            3'b011:  op = rv_core_pkg::ALU_SLTU;
            3'b100:  op = rv_core_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  op = rv_core_pkg::ALU_OR;
            default: op = rv_core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rd_o  = instr_i[11:7];
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_core_pkg::ALU_ADD;
        case (opcode)
            `RV_OPC_OP: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_op_of(funct3, funct7[5]);
                // 0x20 is only defined for sub and sra.
                if (funct7 == 7'h20) begin
                    ctrl.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    ctrl.illegal = (funct7 != 7'h00);
                end
            end
            `RV_OPC_OPIMM: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                // only the shifts carry a funct7 field.
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl.alu_op  = alu_op_of(funct3, funct7[5]);
                    ctrl.illegal = (funct7 != 7'h00) &&
                                   !(funct3 == 3'b101 && funct7 == 7'h20);
                end else begin
                    ctrl.alu_op = alu_op_of(funct3, 1'b0);
                end
            end
            `RV_OPC_LUI: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_lui = 1'b1;
                ctrl.alu_op = rv_core_pkg::ALU_PASS_B;
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    assign ctrl_o = ctrl;

    // writes to x0 are dropped here, not in the regfile.
    assign wb_en_o = rst_ni && instr_valid_i && ctrl.reg_we && !ctrl.illegal &&
                     (rd_o != '0);

    assign illegal_o = rst_ni && instr_valid_i && ctrl.illegal;

    // a strobed instruction must carry defined bits.
    always_comb begin
        assert final (!(rst_ni && instr_valid_i) || !$isunknown(instr_i))
            else $error("rv_decoder: valid instruction with unknown bits");
    end

endmodule

/* hw/rv_imm_gen.sv */
`timescale 1ns/10ps

module rv_imm_gen (
    input  rv_core_pkg::instr_t instr_i,
    input  rv_core_pkg::ctrl_t  ctrl_i,
    output rv_core_pkg::word_t  imm_o
);

    logic is_shift;

    assign is_shift = (ctrl_i.alu_op == rv_core_pkg::ALU_SLL) ||
                      (ctrl_i.alu_op == rv_core_pkg::ALU_SRL) ||
                      (ctrl_i.alu_op == rv_core_pkg::ALU_SRA);

    always_comb begin
        if (ctrl_i.is_lui) begin
            // upper 20 bits, low 12 cleared.
            imm_o = {instr_i[31:12], 12'h000};
        end else if (is_shift) begin
            // shamt only, bit 30 is the sra select.
            imm_o = {27'd0, instr_i[24:20]};
        end else begin
            imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
        end
    end

endmodule

/* hw/rv_regfile.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_regfile (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  rv_core_pkg::reg_addr_t rs1_i,
    input  rv_core_pkg::reg_addr_t rs2_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    input  rv_core_pkg::word_t     wd_i,
    input  logic                   we_i,
    output rv_core_pkg::word_t     rd1_o,
    output rv_core_pkg::word_t     rd2_o,
    output logic [1:0]             led_o
);

    // x0 has no storage.
    rv_core_pkg::word_t regs_q [1:`RV_NREGS-1];

    function automatic rv_core_pkg::word_t read_reg(input rv_core_pkg::reg_addr_t addr);
        rv_core_pkg::word_t data;
        data = '0;
        for (int i = 1; i < `RV_NREGS; i++) begin
            if (addr == i) begin
                data = regs_q[i];
            end
        end
        return data;
    endfunction

    // write lands mid-cycle, ready for the next instruction.
    always_ff @(negedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                if (rd_i == i) begin
                    regs_q[i] <= wd_i;
                end
            end
        end
    end

    assign rd1_o = rst_ni ? read_reg(rs1_i) : '0;
    assign rd2_o = rst_ni ? read_reg(rs2_i) : '0;

    // bits swapped to match the board wiring.
    assign led_o = {regs_q[`RV_LED_REG][0], regs_q[`RV_LED_REG][1]};

    assert property (@(negedge clk_i) disable iff (!rst_ni) we_i |-> rd_i != '0)
        else $error("rv_regfile: write enable asserted for x0");

endmodule

/* include/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath width.
`define RV_XLEN 32

// architectural register file size.
`define RV_NREGS 32

// bits needed to index the register file.
`define RV_RADDR_W 5

// major opcodes of the supported subset.
`define RV_OPC_OP 7'b0110011
`define RV_OPC_OPIMM 7'b0010011
`define RV_OPC_LUI 7'b0110111

// register whose low bits drive the board leds.
`define RV_LED_REG 17

`endif

/* rv_core_top.f */
+incdir+include
hw/rv_core_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_imm_gen.sv
hw/rv_alu.sv
hw/rv_core_top.sv
sim/rv_core_tb.sv

/* sim/rv_core_tb.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_core_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int N_RANDOM     = 1200;
    // two resets, two read sweeps and the random phases.
    localparam int TOTAL_CYCLES = 2 * (RESET_CYCLES + 1 + `RV_NREGS) + N_RANDOM + 4;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD + 2000;

    logic                   clk;
    logic                   rst_n;
    rv_core_pkg::instr_t    instr;
    logic                   instr_valid;
    logic                   wb_en;
    rv_core_pkg::reg_addr_t wb_rd;
    rv_core_pkg::word_t     wb_data;
    logic                   illegal;
    logic [1:0]             led;

    rv_core_pkg::word_t     shadow_q [0:`RV_NREGS-1];
    logic [31:0]            lfsr_q;
    rv_core_pkg::reg_addr_t last_rd;
    int                     data_errs;
    int                     ctrl_errs;
    int                     led_errs;

    logic                   exp_legal;
    logic                   exp_wb_en;
    logic                   exp_illegal;
    rv_core_pkg::reg_addr_t exp_rd;
    rv_core_pkg::word_t     exp_data;
    logic [1:0]             exp_led;

    rv_core_top DUT (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .wb_en_o       (wb_en),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .illegal_o     (illegal),
        .led_o         (led)
    );

    // galois lfsr, one step per bit drawn.
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    function automatic logic legal_instr(input rv_core_pkg::instr_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = ins[14:12];
        f7 = ins[31:25];
        case (ins[6:0])
            `RV_OPC_OP: begin
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end
            `RV_OPC_OPIMM: begin
                if (f3 == 3'd1) begin
                    ok = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    ok = (f7 == 7'h00) || (f7 == 7'h20);
                end else begin
                    ok = 1'b1;
                end
            end
            `RV_OPC_LUI: ok = 1'b1;
            default:     ok = 1'b0;
        endcase
        return ok;
    endfunction

    // rv32i semantics for the supported subset.
    function automatic rv_core_pkg::word_t model_result(
        input rv_core_pkg::instr_t ins,
        input rv_core_pkg::word_t  a,
        input rv_core_pkg::word_t  b
    );
        rv_core_pkg::word_t op2;
        rv_core_pkg::word_t res;
        logic               is_imm;
        logic               alt;
        is_imm = (ins[6:0] == `RV_OPC_OPIMM);
        op2    = is_imm ? {{20{ins[31]}}, ins[31:20]} : b;
        // bit 30 is sub in reg-reg form only, sra in both.
        alt    = ins[30] && (!is_imm || ins[14:12] == 3'd5);
        case (ins[14:12])
            3'd0:    res = alt ? a - op2 : a + op2;
            3'd1:    res = a << op2[4:0];
            3'd2:    res = ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
            3'd3:    res = (a < op2) ? 32'd1 : 32'd0;
            3'd4:    res = a ^ op2;
            3'd5:    res = alt ? $unsigned($signed(a) >>> op2[4:0]) : a >> op2[4:0];
            3'd6:    res = a | op2;
            default: res = a & op2;
        endcase
        if (ins[6:0] == `RV_OPC_LUI) begin
            res = {ins[31:12], 12'h000};
        end
        return res;
    endfunction

    function automatic rv_core_pkg::instr_t random_instr(input rv_core_pkg::reg_addr_t prev_rd);
        logic [3:0]             cls;
        logic [2:0]             f3;
        logic [6:0]             f7;
        logic [6:0]             opc;
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::reg_addr_t rs1;
        rv_core_pkg::reg_addr_t rs2;
        logic [11:0]            imm;
        rv_core_pkg::instr_t    ins;
        cls = 4'(draw_bits(4));
        f3  = 3'(draw_bits(3));
        rd  = 5'(draw_bits(5));
        rs1 = 5'(draw_bits(5));
        rs2 = 5'(draw_bits(5));
        imm = 12'(draw_bits(12));
        f7  = (draw_bits(1) == 1 && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        // lean on the last destination to cover back-to-back use.
        if (draw_bits(2) == 0) begin
            rs1 = prev_rd;
        end
        if (cls == 4'd0) begin
            case (draw_bits(2))
                0, 1: begin
                    opc = 7'(draw_bits(7));
                    if (opc == `RV_OPC_OP || opc == `RV_OPC_OPIMM || opc == `RV_OPC_LUI) begin
                        opc = 7'b0000011;
                    end
                    ins = {imm, rs1, f3, rd, opc};
                end
                2: begin
                    ins = {7'(draw_bits(7)) | 7'h01, rs2, rs1, f3, rd, `RV_OPC_OP};
                end
                default: begin
                    f3  = (draw_bits(1) == 1) ? 3'd5 : 3'd1;
                    ins = {7'(draw_bits(7)) | 7'h01, rs2, rs1, f3, rd, `RV_OPC_OPIMM};
                end
            endcase
        end else if (cls <= 4'd6) begin
            ins = {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
        end else if (cls <= 4'd12) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                ins = {f7, imm[4:0], rs1, f3, rd, `RV_OPC_OPIMM};
            end else begin
                ins = {imm, rs1, f3, rd, `RV_OPC_OPIMM};
            end
        end else if (cls <= 4'd14) begin
            ins = {imm, rs1, f3, rd, `RV_OPC_LUI};
        end else begin
            // addi into the led register from x0.
            ins = {imm, 5'd0, 3'b000, 5'(`RV_LED_REG), `RV_OPC_OPIMM};
        end
        return ins;
    endfunction

    task automatic issue(input rv_core_pkg::instr_t ins, input logic valid);
        @(posedge clk);
        instr       <= ins;
        instr_valid <= valid;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n       <= 1'b0;
        instr_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // add x0, xi, x(31-i) reads every register and writes nothing.
    task automatic sweep_reads();
        for (int i = 0; i < `RV_NREGS; i++) begin
            issue({7'h00, 5'(`RV_NREGS - 1 - i), 5'(i), 3'b000, 5'd0, `RV_OPC_OP}, 1'b1);
        end
    endtask

    task automatic run_random(input int count);
        rv_core_pkg::instr_t ins;
        logic                valid;
        for (int n = 0; n < count; n++) begin
            ins   = random_instr(last_rd);
            valid = (draw_bits(3) != 0);
            if (valid) begin
                last_rd = ins[11:7];
            end
            issue(ins, valid);
        end
    endtask

    always_comb begin
        exp_legal   = legal_instr(instr);
        exp_rd      = instr[11:7];
        exp_wb_en   = rst_n && instr_valid && exp_legal && (exp_rd != '0);
        exp_illegal = rst_n && instr_valid && !exp_legal;
        exp_data    = model_result(instr, shadow_q[instr[19:15]], shadow_q[instr[24:20]]);
        exp_led     = {shadow_q[`RV_LED_REG][0], shadow_q[`RV_LED_REG][1]};
    end

    // shadow registers follow the mid-cycle write.
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                shadow_q[i] <= '0;
            end
        end else if (exp_wb_en) begin
            shadow_q[exp_rd] <= exp_data;
        end
    end

    assert property (@(negedge clk) disable iff (!rst_n) wb_en == exp_wb_en)
        else begin
            ctrl_errs++;
            $display("MISMATCH t=%0t wb_en_o expected %0b actual %0b",
                     $time, $sampled(exp_wb_en), $sampled(wb_en));
        end

    assert property (@(negedge clk) disable iff (!rst_n) illegal == exp_illegal)
        else begin
            ctrl_errs++;
            $display("MISMATCH t=%0t illegal_o expected %0b actual %0b",
                     $time, $sampled(exp_illegal), $sampled(illegal));
        end

    assert property (@(negedge clk) disable iff (!rst_n) exp_wb_en |-> wb_rd == exp_rd)
        else begin
            ctrl_errs++;
            $display("MISMATCH t=%0t wb_rd_o expected %0d actual %0d",
                     $time, $sampled(exp_rd), $sampled(wb_rd));
        end

    assert property (@(negedge clk) disable iff (!rst_n)
                     (instr_valid && exp_legal) |-> wb_data == exp_data)
        else begin
            data_errs++;
            $display("MISMATCH t=%0t wb_data_o expected %08h actual %08h",
                     $time, $sampled(exp_data), $sampled(wb_data));
        end

    assert property (@(negedge clk) disable iff (!rst_n) led == exp_led)
        else begin
            led_errs++;
            $display("MISMATCH t=%0t led_o expected %02b actual %02b",
                     $time, $sampled(exp_led), $sampled(led));
        end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        lfsr_q      = 32'h8d16_a29e;
        last_rd     = '0;
        data_errs   = 0;
        ctrl_errs   = 0;
        led_errs    = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        sweep_reads();
        run_random(N_RANDOM / 2);
        // mid-run reset, then everything must read zero again.
        apply_reset();
        sweep_reads();
        run_random(N_RANDOM / 2);
        @(posedge clk);
        instr_valid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("errors: data %0d, control %0d, led %0d", data_errs, ctrl_errs, led_errs);
        if (data_errs + ctrl_errs + led_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
